/* verilog.f */
+incdir+hw
hw/axi_target_pkg.sv
hw/axi_channel_if.sv
hw/axi_read_responder.sv
hw/axi_write_responder.sv
hw/axi_transaction_log.sv
hw/axi_target_top.sv
bench/axi_target_assert.sv
bench/axi_target_tb.sv

/* bench/axi_target_tb.sv */
`timescale 1ns/1ps
`include "axi_target_defines.svh"

module axi_target_tb;

    logic                         axi_clk = 1'b0;
    logic                         i_reset;
    logic                         i_awvalid, i_awlock, i_arvalid, i_arlock;
    logic                         i_wvalid, i_wlast, i_bready, i_rready;
    logic                         o_awready, o_arready, o_wready;
    logic                         o_bvalid, o_rvalid, o_rlast;
    axi_target_pkg::axi_addr_t    i_awaddr, i_araddr;
    axi_target_pkg::axi_len_t     i_awlen, i_arlen;
    axi_target_pkg::axi_size_t    i_awsize, i_arsize;
    axi_target_pkg::axi_burst_t   i_awburst, i_arburst;
    axi_target_pkg::axi_prot_t    i_awprot, i_arprot;
    axi_target_pkg::axi_cache_t   i_awcache, i_arcache;
    axi_target_pkg::axi_data_t    i_wdata, o_rdata;
    axi_target_pkg::axi_strb_t    i_wstrb;
    axi_target_pkg::axi_resp_t    o_bresp, o_rresp;
    axi_target_pkg::log_channel_e i_log_channel;
    axi_target_pkg::log_index_t   i_log_index;
    axi_target_pkg::log_hex_t     o_log_hex;
    axi_target_pkg::log_bin_t     o_log_bin;

    // Reference model, log entries packed as {hex, bin} and newest first
    logic [31:0] rng_state = 32'hb5d9;
    logic        rd_busy;
    logic        wr_busy;
    int          rd_count;
    int          wr_count;
    logic [76:0] aw_log[$];
    logic [76:0] ar_log[$];
    logic [76:0] w_log[$];

    axi_target_top dut (.*);

    always #20 axi_clk = ~axi_clk;

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(logic [76:0] actual, logic [76:0] expected, string what);
        if (actual !== expected) begin
            fail_run($sformatf("error at %0t ns: %s got %h expected %h",
                               $time, what, actual, expected));
        end
    endtask

    always @(negedge axi_clk) begin
        if (dut.u_assert.fail_count != 0) begin
            fail_run("a handshake assertion failed");
        end
    end

    ////////////////////////////////////////
    // Random traffic, one clock per call
    ////////////////////////////////////////

    task automatic traffic_cycle(logic active);
        logic [31:0] r;
        logic        ar_hs;
        logic        wr_hs;
        r = next_random();
        i_awvalid = active & r[0];
        i_wvalid  = active & (r[1] | r[2]);
        i_arvalid = active & r[3];
        // Idle cycles keep both readies high so responses drain
        i_bready  = ~active | r[4] | r[5];
        i_rready  = ~active | r[6] | r[7];
        i_awaddr  = next_random();
        r = next_random();
        {i_awlen, i_awsize, i_awburst, i_awprot, i_awlock, i_awcache} = r[20:0];
        i_araddr  = next_random();
        r = next_random();
        {i_arlen, i_arsize, i_arburst, i_arprot, i_arlock, i_arcache} = r[20:0];
        i_wdata   = {next_random(), next_random()};
        r = next_random();
        {i_wstrb, i_wlast} = r[8:0];

        @(negedge axi_clk);
        check_value(o_arready, !rd_busy, "arready");
        check_value(o_rvalid, rd_busy, "rvalid");
        check_value(o_awready, i_awvalid && i_wvalid && !wr_busy, "awready");
        check_value(o_wready, i_awvalid && i_wvalid && !wr_busy, "wready");
        check_value(o_bvalid, wr_busy, "bvalid");
        if (rd_busy) begin
            check_value(o_rdata, `READ_PATTERN, "rdata");
            check_value(o_rlast, 1'b1, "rlast");
            check_value(o_rresp, `RESP_OKAY, "rresp");
        end
        if (wr_busy) begin
            check_value(o_bresp, `RESP_OKAY, "bresp");
        end

        ar_hs = i_arvalid && o_arready;
        wr_hs = i_awvalid && o_awready && i_wvalid && o_wready;
        if (ar_hs) begin
            ar_log.push_front({24'h0, i_araddr, i_arlen, i_arsize, i_arburst, i_arprot,
                               i_arlock, i_arcache});
            rd_count++;
        end
        if (wr_hs) begin
            aw_log.push_front({24'h0, i_awaddr, i_awlen, i_awsize, i_awburst, i_awprot,
                               i_awlock, i_awcache});
            w_log.push_front({i_wdata, 4'h0, i_wstrb, i_wlast});
            wr_count++;
        end

        @(posedge axi_clk);
        if (rd_busy && i_rready) begin
            rd_busy = 1'b0;
        end else if (ar_hs) begin
            rd_busy = 1'b1;
        end
        if (wr_busy && i_bready) begin
            wr_busy = 1'b0;
        end else if (wr_hs) begin
            wr_busy = 1'b1;
        end
        #2;
    endtask

    task automatic run_traffic(int reads, int writes);
        int cycles;
        cycles = 0;
        while (rd_count < reads || wr_count < writes) begin
            if (cycles == 2000) begin
                fail_run("timeout: random traffic produced too few handshakes");
            end
            traffic_cycle(1'b1);
            cycles++;
        end
        cycles = 0;
        while (rd_busy || wr_busy) begin
            if (cycles == 10) begin
                fail_run("timeout: pending responses did not drain");
            end
            traffic_cycle(1'b0);
            cycles++;
        end
    endtask

    ////////////////////////////////////////
    // Log queries
    ////////////////////////////////////////

    // Called 2 ns after a rising edge, returns at the same point
    task automatic query_entry(axi_target_pkg::log_channel_e ch, int idx,
                               logic [76:0] expected);
        i_log_channel = ch;
        i_log_index   = axi_target_pkg::log_index_t'(idx);
        @(posedge axi_clk);
        @(negedge axi_clk);
        check_value({o_log_hex, o_log_bin}, expected,
                    $sformatf("log channel %0d index %0d", ch, idx));
        @(posedge axi_clk);
        #2;
    endtask

    task automatic check_logs();
        for (int i = 0; i < `LOG_DEPTH; i++) begin
            query_entry(axi_target_pkg::LOG_AW, i, i < aw_log.size() ? aw_log[i] : '0);
            query_entry(axi_target_pkg::LOG_AR, i, i < ar_log.size() ? ar_log[i] : '0);
            query_entry(axi_target_pkg::LOG_W, i, i < w_log.size() ? w_log[i] : '0);
        end
    endtask

    initial begin
        i_reset       = 1'b1;
        i_awvalid     = 1'b0;
        i_arvalid     = 1'b0;
        i_wvalid      = 1'b0;
        i_bready      = 1'b0;
        i_rready      = 1'b0;
        {i_awaddr, i_awlen, i_awsize, i_awburst, i_awprot, i_awlock, i_awcache} = '0;
        {i_araddr, i_arlen, i_arsize, i_arburst, i_arprot, i_arlock, i_arcache} = '0;
        {i_wdata, i_wstrb, i_wlast} = '0;
        i_log_channel = axi_target_pkg::LOG_AW;
        i_log_index   = '0;
        rd_busy       = 1'b0;
        wr_busy       = 1'b0;
        rd_count      = 0;
        wr_count      = 0;

        repeat (10) @(posedge axi_clk);
        #2;
        i_reset = 1'b0;
        check_value(o_rvalid, 1'b0, "rvalid after reset");
        check_value(o_bvalid, 1'b0, "bvalid after reset");
        check_logs();

        // Short burst leaves part of each history empty
        run_traffic(2, 2);
        check_logs();
        run_traffic(30, 30);
        check_logs();

        if (dut.u_assert.fail_count != 0) begin
            fail_run("handshake assertions failed during the run");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

/* bench/axi_target_assert.sv */
`timescale 1ns/1ps
`include "axi_target_defines.svh"

module axi_target_assert (
    input logic                      axi_clk,
    input logic                      i_reset,
    input logic                      i_awready,
    input logic                      i_wready,
    input logic                      i_bvalid,
    input logic                      i_bready,
    input logic                      i_rvalid,
    input logic                      i_rready,
    input axi_target_pkg::axi_data_t i_rdata
);

    // Number of failed assertions so far
    int fail_count = 0;

    ////////////////////////////////////////
    // Response hold until taken
    ////////////////////////////////////////

    rvalid_held: assert property (@(posedge axi_clk) disable iff (i_reset)
        i_rvalid && !i_rready |=> i_rvalid)
        else begin
            fail_count++;
            $error("rvalid dropped before rready");
        end

    bvalid_held: assert property (@(posedge axi_clk) disable iff (i_reset)
        i_bvalid && !i_bready |=> i_bvalid)
        else begin
            fail_count++;
            $error("bvalid dropped before bready");
        end

    // Address and data are only taken as a pair
    ready_pair: assert property (@(posedge axi_clk) disable iff (i_reset)
        i_awready == i_wready)
        else begin
            fail_count++;
            $error("awready and wready differ");
        end

    rdata_fixed: assert property (@(posedge axi_clk) disable iff (i_reset)
        i_rvalid |-> i_rdata == `READ_PATTERN)
        else begin
            fail_count++;
            $error("rdata differs from the read pattern");
        end

endmodule

bind axi_target_top axi_target_assert u_assert (
    .axi_clk   (axi_clk),
    .i_reset   (i_reset),
    .i_awready (o_awready),
    .i_wready  (o_wready),
    .i_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .i_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .i_rdata   (o_rdata)
);

/* hw/axi_target_top.sv */
`timescale 1ns/1ps

module axi_target_top (
    input  logic                         axi_clk,
    input  logic                         i_reset,
    // AW
    input  logic                         i_awvalid,
    input  axi_target_pkg::axi_addr_t    i_awaddr,
    input  axi_target_pkg::axi_len_t     i_awlen,
    input  axi_target_pkg::axi_size_t    i_awsize,
    input  axi_target_pkg::axi_burst_t   i_awburst,
    input  axi_target_pkg::axi_prot_t    i_awprot,
    input  logic                         i_awlock,
    input  axi_target_pkg::axi_cache_t   i_awcache,
    output logic                         o_awready,
    // AR
    input  logic                         i_arvalid,
    input  axi_target_pkg::axi_addr_t    i_araddr,
    input  axi_target_pkg::axi_len_t     i_arlen,
    input  axi_target_pkg::axi_size_t    i_arsize,
    input  axi_target_pkg::axi_burst_t   i_arburst,
    input  axi_target_pkg::axi_prot_t    i_arprot,
    input  logic                         i_arlock,
    input  axi_target_pkg::axi_cache_t   i_arcache,
    output logic                         o_arready,
    // W
    input  logic                         i_wvalid,
    input  axi_target_pkg::axi_data_t    i_wdata,
    input  axi_target_pkg::axi_strb_t    i_wstrb,
    input  logic                         i_wlast,
    output logic                         o_wready,
    // B
    output logic                         o_bvalid,
    output axi_target_pkg::axi_resp_t    o_bresp,
    input  logic                         i_bready,
    // R
    output logic                         o_rvalid,
    output axi_target_pkg::axi_data_t    o_rdata,
    output logic                         o_rlast,
    output axi_target_pkg::axi_resp_t    o_rresp,
    input  logic                         i_rready,
    // Log query
    input  axi_target_pkg::log_channel_e i_log_channel,
    input  axi_target_pkg::log_index_t   i_log_index,
    output axi_target_pkg::log_hex_t     o_log_hex,
    output axi_target_pkg::log_bin_t     o_log_bin
);

    axi_addr_if  aw_bus ();
    axi_addr_if  ar_bus ();
    axi_wdata_if w_bus ();

    ////////////////////////////////////////
    // Port bundling
    ////////////////////////////////////////

    assign aw_bus.valid = i_awvalid;
    assign aw_bus.addr  = i_awaddr;
    assign aw_bus.len   = i_awlen;
    assign aw_bus.size  = i_awsize;
    assign aw_bus.burst = i_awburst;
    assign aw_bus.prot  = i_awprot;
    assign aw_bus.lock  = i_awlock;
    assign aw_bus.cache = i_awcache;
    assign o_awready    = aw_bus.ready;

    assign ar_bus.valid = i_arvalid;
    assign ar_bus.addr  = i_araddr;
    assign ar_bus.len   = i_arlen;
    assign ar_bus.size  = i_arsize;
    assign ar_bus.burst = i_arburst;
    assign ar_bus.prot  = i_arprot;
    assign ar_bus.lock  = i_arlock;
    assign ar_bus.cache = i_arcache;
    assign o_arready    = ar_bus.ready;

    assign w_bus.valid = i_wvalid;
    assign w_bus.data  = i_wdata;
    assign w_bus.strb  = i_wstrb;
    assign w_bus.last  = i_wlast;
    assign o_wready    = w_bus.ready;

    ////////////////////////////////////////
    // Responders and monitor
    ////////////////////////////////////////

    axi_read_responder u_read (
        .axi_clk  (axi_clk),
        .i_reset  (i_reset),
        .ar       (ar_bus.responder),
        .o_rvalid (o_rvalid),
        .o_rdata  (o_rdata),
        .o_rlast  (o_rlast),
        .o_rresp  (o_rresp),
        .i_rready (i_rready)
    );

    axi_write_responder u_write (
        .axi_clk  (axi_clk),
        .i_reset  (i_reset),
        .aw       (aw_bus.responder),
        .w        (w_bus.responder),
        .o_bvalid (o_bvalid),
        .o_bresp  (o_bresp),
        .i_bready (i_bready)
    );

    axi_transaction_log u_log (
        .axi_clk       (axi_clk),
        .i_reset       (i_reset),
        .aw            (aw_bus.monitor),
        .ar            (ar_bus.monitor),
        .w             (w_bus.monitor),
        .i_log_channel (i_log_channel),
        .i_log_index   (i_log_index),
        .o_log_hex     (o_log_hex),
        .o_log_bin     (o_log_bin)
    );

endmodule

/* hw/axi_transaction_log.sv */
`timescale 1ns/1ps
`include "axi_target_defines.svh"

module axi_transaction_log (
    input  logic                         axi_clk,
    input  logic                         i_reset,
    axi_addr_if.monitor                  aw,
    axi_addr_if.monitor                  ar,
    axi_wdata_if.monitor                 w,
    input  axi_target_pkg::log_channel_e i_log_channel,
    input  axi_target_pkg::log_index_t   i_log_index,
    output axi_target_pkg::log_hex_t     o_log_hex,
    output axi_target_pkg::log_bin_t     o_log_bin
);

    // Index 0 holds the newest entry
    axi_target_pkg::log_hex_t aw_hex [`LOG_DEPTH];
    axi_target_pkg::log_bin_t aw_bin [`LOG_DEPTH];
    axi_target_pkg::log_hex_t ar_hex [`LOG_DEPTH];
    axi_target_pkg::log_bin_t ar_bin [`LOG_DEPTH];
    axi_target_pkg::log_hex_t w_hex [`LOG_DEPTH];
    axi_target_pkg::log_bin_t w_bin [`LOG_DEPTH];

    // Address in bits 39:8, length in 7:0
    function automatic axi_target_pkg::log_hex_t addr_hex(axi_target_pkg::axi_addr_t addr,
                                                          axi_target_pkg::axi_len_t len);
        return axi_target_pkg::log_hex_t'({addr, len});
    endfunction

    ////////////////////////////////////////
    // Shift histories
    ////////////////////////////////////////

    always_ff @(posedge axi_clk) begin
        if (i_reset) begin
            for (int k = 0; k < `LOG_DEPTH; k++) begin
                aw_hex[k] <= '0;
                aw_bin[k] <= '0;
                ar_hex[k] <= '0;
                ar_bin[k] <= '0;
                w_hex[k]  <= '0;
                w_bin[k]  <= '0;
            end
        end else begin
            if (aw.accept) begin
                aw_hex[0] <= addr_hex(aw.addr, aw.len);
                aw_bin[0] <= {aw.size, aw.burst, aw.prot, aw.lock, aw.cache};
                for (int k = 1; k < `LOG_DEPTH; k++) begin
                    aw_hex[k] <= aw_hex[k-1];
                    aw_bin[k] <= aw_bin[k-1];
                end
            end
            if (ar.accept) begin
                ar_hex[0] <= addr_hex(ar.addr, ar.len);
                ar_bin[0] <= {ar.size, ar.burst, ar.prot, ar.lock, ar.cache};
                for (int k = 1; k < `LOG_DEPTH; k++) begin
                    ar_hex[k] <= ar_hex[k-1];
                    ar_bin[k] <= ar_bin[k-1];
                end
            end
            if (w.accept) begin
                w_hex[0] <= w.data;
                // Strobes over last in the low 9 bits
                w_bin[0] <= axi_target_pkg::log_bin_t'({w.strb, w.last});
                for (int k = 1; k < `LOG_DEPTH; k++) begin
                    w_hex[k] <= w_hex[k-1];
                    w_bin[k] <= w_bin[k-1];
                end
            end
        end
    end

    ////////////////////////////////////////
    // Query readout, one cycle latency
    ////////////////////////////////////////

    always_ff @(posedge axi_clk) begin
        if (i_reset) begin
            o_log_hex <= '0;
            o_log_bin <= '0;
        end else begin
            case (i_log_channel)
                axi_target_pkg::LOG_AW: begin
                    o_log_hex <= aw_hex[i_log_index];
                    o_log_bin <= aw_bin[i_log_index];
                end
                axi_target_pkg::LOG_AR: begin
                    o_log_hex <= ar_hex[i_log_index];
                    o_log_bin <= ar_bin[i_log_index];
                end
                axi_target_pkg::LOG_W: begin
                    o_log_hex <= w_hex[i_log_index];
                    o_log_bin <= w_bin[i_log_index];
                end
                default: begin
                    o_log_hex <= '0;
                    o_log_bin <= '0;
                end
            endcase
        end
    end

endmodule

/* hw/axi_write_responder.sv */
`timescale 1ns/1ps
`include "axi_target_defines.svh"

module axi_write_responder (
    input  logic                      axi_clk,
    input  logic                      i_reset,
    axi_addr_if.responder             aw,
    axi_wdata_if.responder            w,
    output logic                      o_bvalid,
    output axi_target_pkg::axi_resp_t o_bresp,
    input  logic                      i_bready
);

    logic rsp_pending;
    logic pair_hs;

    ////////////////////////////////////////
    // Paired AW and W acceptance
    ////////////////////////////////////////

    // Address and data only go in together, and only with B free
    assign pair_hs = aw.valid & w.valid & ~rsp_pending;

    assign aw.ready = pair_hs;
    assign w.ready  = pair_hs;

    // Same strobe for both logs
    assign aw.accept = pair_hs;
    assign w.accept  = pair_hs;

    ////////////////////////////////////////
    // B channel
    ////////////////////////////////////////

    always_ff @(posedge axi_clk) begin
        if (i_reset) begin
            rsp_pending <= 1'b0;
        end else if (rsp_pending && i_bready) begin
            rsp_pending <= 1'b0;
        end else if (pair_hs) begin
            rsp_pending <= 1'b1;
        end
    end

    assign o_bvalid = rsp_pending;
    assign o_bresp  = `RESP_OKAY;

endmodule

/* hw/axi_read_responder.sv */
`timescale 1ns/1ps
`include "axi_target_defines.svh"

module axi_read_responder (
    input  logic                      axi_clk,
    input  logic                      i_reset,
    axi_addr_if.responder             ar,
    output logic                      o_rvalid,
    output axi_target_pkg::axi_data_t o_rdata,
    output logic                      o_rlast,
    output axi_target_pkg::axi_resp_t o_rresp,
    input  logic                      i_rready
);

    logic rsp_pending;
    logic addr_hs;

    // One read in flight, address stalls until R is taken
    assign ar.ready = ~rsp_pending;
    assign addr_hs  = ar.valid & ~rsp_pending;
    assign ar.accept = addr_hs;

    always_ff @(posedge axi_clk) begin
        if (i_reset) begin
            rsp_pending <= 1'b0;
        end else if (rsp_pending && i_rready) begin
            rsp_pending <= 1'b0;
        end else if (addr_hs) begin
            rsp_pending <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // R channel
    ////////////////////////////////////////

    // Single beat of the fixed pattern
    assign o_rvalid = rsp_pending;
    assign o_rdata  = `READ_PATTERN;
    assign o_rlast  = 1'b1;
    assign o_rresp  = `RESP_OKAY;

endmodule

/* hw/axi_channel_if.sv */
`timescale 1ns/1ps

// Address channel, one instance each for AW and AR
interface axi_addr_if;
    logic                       valid;
    logic                       ready;
    axi_target_pkg::axi_addr_t  addr;
    axi_target_pkg::axi_len_t   len;
    axi_target_pkg::axi_size_t  size;
    axi_target_pkg::axi_burst_t burst;
    axi_target_pkg::axi_prot_t  prot;
    logic                       lock;
    axi_target_pkg::axi_cache_t cache;
    // High in the cycle of a completed handshake
    logic                       accept;

    modport responder (input valid, output ready, output accept);

    modport monitor (
        input valid, ready, addr, len, size, burst, prot, lock, cache, accept
    );
endinterface

// Write data channel
interface axi_wdata_if;
    logic                      valid;
    logic                      ready;
    axi_target_pkg::axi_data_t data;
    axi_target_pkg::axi_strb_t strb;
    logic                      last;
    logic                      accept;

    modport responder (input valid, output ready, output accept);

    modport monitor (input valid, ready, data, strb, last, accept);
endinterface

/* hw/axi_target_pkg.sv */
`include "axi_target_defines.svh"

package axi_target_pkg;

    ////////////////////////////////////////
    // AXI field types
    ////////////////////////////////////////

    typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [`AXI_LEN_W-1:0] axi_len_t;
    typedef logic [2:0] axi_size_t;
    typedef logic [1:0] axi_burst_t;
    typedef logic [2:0] axi_prot_t;
    typedef logic [3:0] axi_cache_t;
    typedef logic [`AXI_DATA_W-1:0] axi_data_t;
    typedef logic [`AXI_DATA_W/8-1:0] axi_strb_t;
    typedef logic [1:0] axi_resp_t;

    ////////////////////////////////////////
    // Transaction log types
    ////////////////////////////////////////

    // Numeric part wide enough for a full data beat
    typedef logic [`AXI_DATA_W-1:0] log_hex_t;
    // Size, burst, prot, lock and cache packed together
    typedef logic [12:0] log_bin_t;
    // 0 selects the newest entry
    typedef logic [$clog2(`LOG_DEPTH)-1:0] log_index_t;

    typedef enum logic [1:0] {LOG_AW, LOG_AR, LOG_W} log_channel_e;

endpackage

/* hw/axi_target_defines.svh */
`ifndef AXI_TARGET_DEFINES_SVH
`define AXI_TARGET_DEFINES_SVH

////////////////////////////////////////
// Bus widths
////////////////////////////////////////

`define AXI_ADDR_W 32
`define AXI_DATA_W 64
`define AXI_LEN_W 8

////////////////////////////////////////
// Transaction log and fixed responses
////////////////////////////////////////

// Entries kept per channel
`define LOG_DEPTH 8
`define READ_PATTERN 64'h0000_1234_5678_0000
`define RESP_OKAY 2'b00

`endif
